// File: verilog/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data and address width
`define XLEN      32
`define INST_LEN  32

// architectural register file depth
`define REG_COUNT 32

// first fetch address out of reset
`define RESET_PC  32'h0000_0000

`endif

// File: verilog/rv_isa_pkg.sv
`include "core_config.svh"

package rv_isa_pkg;

    typedef logic [`XLEN-1:0]     xlen_t;
    typedef logic [`INST_LEN-1:0] inst_t;
    typedef logic [4:0]           reg_idx_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // pass_b forwards operand b, used by lui
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

endpackage

// File: verilog/pipe_pkg.sv
package pipe_pkg;

    // pipeline_ctrl states
    typedef enum logic [1:0] {
        CTRL_RUN    = 2'd0,
        CTRL_DRAIN  = 2'd1,
        CTRL_HALTED = 2'd2
    } ctrl_state_e;

    // operand source in execute
    typedef enum logic [0:0] {
        FWD_REGFILE = 1'b0,
        FWD_WB_REG  = 1'b1
    } fwd_sel_e;

endpackage

// File: verilog/fetch_stage.sv
`include "core_config.svh"

module fetch_stage (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              fetch_en_i,
    input  logic              flush_i,
    input  logic              jump_taken_i,
    input  rv_isa_pkg::xlen_t jump_target_i,
    input  rv_isa_pkg::xlen_t sram_rdata_i,
    input  logic              sram_data_valid_i,
    output logic              sram_ren_o,
    output rv_isa_pkg::xlen_t sram_addr_o,
    output logic              if_valid_o,
    output rv_isa_pkg::xlen_t if_pc_o,
    output rv_isa_pkg::inst_t if_instr_o
);

    rv_isa_pkg::xlen_t pc_q;
    rv_isa_pkg::xlen_t issue_pc;
    logic              complete;
    logic              can_issue;
    logic              discard_q;

    assign complete  = sram_ren_o & sram_data_valid_i;
    assign can_issue = ~sram_ren_o | complete;
    // a redirect goes straight to the port when it is free
    assign issue_pc  = jump_taken_i ? jump_target_i : pc_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q        <= `RESET_PC;
            sram_ren_o  <= 1'b0;
            sram_addr_o <= `RESET_PC;
            discard_q   <= 1'b0;
            if_valid_o  <= 1'b0;
        end else begin
            if (can_issue) begin
                sram_ren_o <= fetch_en_i;
            end
            if (can_issue && fetch_en_i) begin
                sram_addr_o <= issue_pc;
                pc_q        <= issue_pc + rv_isa_pkg::xlen_t'(4);
            end else if (jump_taken_i) begin
                pc_q <= jump_target_i;
            end
            // read overtaken by a redirect or drain
            if (complete) begin
                discard_q <= 1'b0;
            end else if (flush_i && sram_ren_o) begin
                discard_q <= 1'b1;
            end
            if_valid_o <= complete & ~discard_q & ~flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (complete) begin
            if_pc_o    <= sram_addr_o;
            if_instr_o <= sram_rdata_i;
        end
    end

endmodule

// File: verilog/decode_stage.sv
`include "core_config.svh"

module decode_stage (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 flush_i,
    input  logic                 if_valid_i,
    input  rv_isa_pkg::xlen_t    if_pc_i,
    input  rv_isa_pkg::inst_t    if_instr_i,
    input  logic                 wb_en_i,
    input  rv_isa_pkg::reg_idx_t wb_idx_i,
    input  rv_isa_pkg::xlen_t    wb_data_i,
    output logic                 id_valid_o,
    output rv_isa_pkg::xlen_t    id_pc_o,
    output rv_isa_pkg::inst_t    id_instr_o,
    output rv_isa_pkg::xlen_t    rs1_data_o,
    output rv_isa_pkg::xlen_t    rs2_data_o,
    output rv_isa_pkg::xlen_t    imm_o,
    output rv_isa_pkg::reg_idx_t rs1_idx_o,
    output rv_isa_pkg::reg_idx_t rs2_idx_o,
    output rv_isa_pkg::reg_idx_t rd_idx_o,
    output rv_isa_pkg::alu_op_e  alu_op_o,
    output logic                 use_imm_o,
    output logic                 is_branch_o,
    output logic                 branch_ne_o,
    output logic                 is_jal_o,
    output logic                 wb_en_o,
    output logic                 is_ebreak_o,
    output rv_isa_pkg::xlen_t    reg_a0_o
);

    rv_isa_pkg::xlen_t    regs [`REG_COUNT];
    rv_isa_pkg::reg_idx_t rs1_idx;
    rv_isa_pkg::reg_idx_t rs2_idx;
    rv_isa_pkg::xlen_t    rs1_rd;
    rv_isa_pkg::xlen_t    rs2_rd;
    rv_isa_pkg::xlen_t    imm;
    rv_isa_pkg::alu_op_e  alu_op;
    logic [2:0]           funct3;
    logic                 use_imm;
    logic                 is_branch;
    logic                 is_jal;
    logic                 wb_en;
    logic                 is_ebreak;

    assign rs1_idx  = if_instr_i[19:15];
    assign rs2_idx  = if_instr_i[24:20];
    assign funct3   = if_instr_i[14:12];
    assign reg_a0_o = regs[10];

    always_ff @(posedge clk) begin
        if (wb_en_i && wb_idx_i != '0) begin
            regs[wb_idx_i] <= wb_data_i;
        end
    end

    // x0 reads zero, same-cycle write goes through
    assign rs1_rd = (rs1_idx == '0) ? '0 :
                    (wb_en_i && wb_idx_i == rs1_idx) ? wb_data_i : regs[rs1_idx];
    assign rs2_rd = (rs2_idx == '0) ? '0 :
                    (wb_en_i && wb_idx_i == rs2_idx) ? wb_data_i : regs[rs2_idx];

    always_comb begin
        alu_op    = rv_isa_pkg::ALU_ADD;
        imm       = '0;
        use_imm   = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        wb_en     = 1'b0;
        is_ebreak = 1'b0;
        case (if_instr_i[6:0])
            rv_isa_pkg::OPC_OP: begin
                wb_en = 1'b1;
                case (funct3)
                    3'b000: alu_op = if_instr_i[30] ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
                    3'b010: alu_op = rv_isa_pkg::ALU_SLT;
                    3'b100: alu_op = rv_isa_pkg::ALU_XOR;
                    3'b110: alu_op = rv_isa_pkg::ALU_OR;
                    3'b111: alu_op = rv_isa_pkg::ALU_AND;
                    default: wb_en = 1'b0;
                endcase
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                wb_en   = 1'b1;
                use_imm = 1'b1;
                imm     = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
                case (funct3)
                    3'b000: alu_op = rv_isa_pkg::ALU_ADD;
                    3'b100: alu_op = rv_isa_pkg::ALU_XOR;
                    3'b110: alu_op = rv_isa_pkg::ALU_OR;
                    3'b111: alu_op = rv_isa_pkg::ALU_AND;
                    default: wb_en = 1'b0;
                endcase
            end
            rv_isa_pkg::OPC_LUI: begin
                wb_en   = 1'b1;
                use_imm = 1'b1;
                alu_op  = rv_isa_pkg::ALU_PASS_B;
                imm     = {if_instr_i[31:12], 12'b0};
            end
            rv_isa_pkg::OPC_BRANCH: begin
                // only beq and bne
                is_branch = (funct3[2:1] == 2'b00);
                imm       = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
                             if_instr_i[30:25], if_instr_i[11:8], 1'b0};
            end
            rv_isa_pkg::OPC_JAL: begin
                is_jal = 1'b1;
                wb_en  = 1'b1;
                imm    = {{11{if_instr_i[31]}}, if_instr_i[31], if_instr_i[19:12],
                          if_instr_i[20], if_instr_i[30:21], 1'b0};
            end
            rv_isa_pkg::OPC_SYSTEM: begin
                is_ebreak = (if_instr_i == 32'h0010_0073);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_valid_o <= 1'b0;
        end else begin
            id_valid_o <= if_valid_i & ~flush_i;
        end
    end

    // flags are qualified by id_valid_o downstream
    always_ff @(posedge clk) begin
        id_pc_o     <= if_pc_i;
        id_instr_o  <= if_instr_i;
        rs1_data_o  <= rs1_rd;
        rs2_data_o  <= rs2_rd;
        imm_o       <= imm;
        rs1_idx_o   <= rs1_idx;
        rs2_idx_o   <= rs2_idx;
        rd_idx_o    <= if_instr_i[11:7];
        alu_op_o    <= alu_op;
        use_imm_o   <= use_imm;
        is_branch_o <= is_branch;
        branch_ne_o <= funct3[0];
        is_jal_o    <= is_jal;
        wb_en_o     <= wb_en;
        is_ebreak_o <= is_ebreak;
    end

endmodule

// File: verilog/execute_stage.sv
module execute_stage (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 id_valid_i,
    input  rv_isa_pkg::xlen_t    id_pc_i,
    input  rv_isa_pkg::inst_t    id_instr_i,
    input  rv_isa_pkg::xlen_t    rs1_data_i,
    input  rv_isa_pkg::xlen_t    rs2_data_i,
    input  rv_isa_pkg::xlen_t    imm_i,
    input  rv_isa_pkg::reg_idx_t rs1_idx_i,
    input  rv_isa_pkg::reg_idx_t rs2_idx_i,
    input  rv_isa_pkg::reg_idx_t rd_idx_i,
    input  rv_isa_pkg::alu_op_e  alu_op_i,
    input  logic                 use_imm_i,
    input  logic                 is_branch_i,
    input  logic                 branch_ne_i,
    input  logic                 is_jal_i,
    input  logic                 wb_en_i,
    input  logic                 is_ebreak_i,
    output logic                 jump_taken_o,
    output rv_isa_pkg::xlen_t    jump_target_o,
    output logic                 halt_seen_o,
    output logic                 wb_en_o,
    output rv_isa_pkg::reg_idx_t wb_idx_o,
    output rv_isa_pkg::xlen_t    wb_data_o,
    output logic                 retire_valid_o,
    output rv_isa_pkg::xlen_t    retire_pc_o,
    output rv_isa_pkg::inst_t    retire_instr_o,
    output logic                 retire_ebreak_o
);

    pipe_pkg::fwd_sel_e rs1_sel;
    pipe_pkg::fwd_sel_e rs2_sel;
    rv_isa_pkg::xlen_t  op_a;
    rv_isa_pkg::xlen_t  op_b_reg;
    rv_isa_pkg::xlen_t  op_b;
    rv_isa_pkg::xlen_t  alu_res;
    rv_isa_pkg::xlen_t  ex_res;
    logic               ops_equal;

    // bypass from the ex/wb register
    assign rs1_sel = (wb_en_o && wb_idx_o != '0 && wb_idx_o == rs1_idx_i) ?
                     pipe_pkg::FWD_WB_REG : pipe_pkg::FWD_REGFILE;
    assign rs2_sel = (wb_en_o && wb_idx_o != '0 && wb_idx_o == rs2_idx_i) ?
                     pipe_pkg::FWD_WB_REG : pipe_pkg::FWD_REGFILE;

    assign op_a     = (rs1_sel == pipe_pkg::FWD_WB_REG) ? wb_data_o : rs1_data_i;
    assign op_b_reg = (rs2_sel == pipe_pkg::FWD_WB_REG) ? wb_data_o : rs2_data_i;
    assign op_b     = use_imm_i ? imm_i : op_b_reg;

    always_comb begin
        case (alu_op_i)
            rv_isa_pkg::ALU_SUB:    alu_res = op_a - op_b;
            rv_isa_pkg::ALU_AND:    alu_res = op_a & op_b;
            rv_isa_pkg::ALU_OR:     alu_res = op_a | op_b;
            rv_isa_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
            rv_isa_pkg::ALU_SLT:    alu_res = rv_isa_pkg::xlen_t'($signed(op_a) < $signed(op_b));
            rv_isa_pkg::ALU_PASS_B: alu_res = op_b;
            default:                alu_res = op_a + op_b;
        endcase
    end

    // jal links pc+4
    assign ex_res    = is_jal_i ? id_pc_i + rv_isa_pkg::xlen_t'(4) : alu_res;
    assign ops_equal = (op_a == op_b_reg);

    assign jump_taken_o  = id_valid_i & (is_jal_i | (is_branch_i & (ops_equal ^ branch_ne_i)));
    assign jump_target_o = id_pc_i + imm_i;
    assign halt_seen_o   = id_valid_i & is_ebreak_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_valid_o  <= 1'b0;
            wb_en_o         <= 1'b0;
            retire_ebreak_o <= 1'b0;
        end else begin
            retire_valid_o  <= id_valid_i;
            wb_en_o         <= id_valid_i & wb_en_i;
            retire_ebreak_o <= id_valid_i & is_ebreak_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_idx_o       <= rd_idx_i;
        wb_data_o      <= ex_res;
        retire_pc_o    <= id_pc_i;
        retire_instr_o <= id_instr_i;
    end

endmodule

// File: verilog/pipeline_ctrl.sv
module pipeline_ctrl (
    input  logic clk,
    input  logic arst_n_i,
    input  logic jump_taken_i,
    input  logic halt_seen_i,
    input  logic retire_valid_i,
    input  logic retire_ebreak_i,
    output logic fetch_en_o,
    output logic flush_o,
    output logic halted_o
);

    pipe_pkg::ctrl_state_e state_q;
    pipe_pkg::ctrl_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            pipe_pkg::CTRL_RUN: begin
                if (halt_seen_i) begin
                    state_d = pipe_pkg::CTRL_DRAIN;
                end
            end
            pipe_pkg::CTRL_DRAIN: begin
                if (retire_valid_i && retire_ebreak_i) begin
                    state_d = pipe_pkg::CTRL_HALTED;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= pipe_pkg::CTRL_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // younger instructions are killed once ebreak is in ex
    assign fetch_en_o = (state_q == pipe_pkg::CTRL_RUN) & ~halt_seen_i;
    assign flush_o    = jump_taken_i | halt_seen_i | (state_q != pipe_pkg::CTRL_RUN);
    assign halted_o   = (state_q == pipe_pkg::CTRL_HALTED);

endmodule

// File: verilog/core_top.sv
module core_top (
    input  logic              clk,
    input  logic              arst_n_i,
    input  rv_isa_pkg::xlen_t sram_rdata_i,
    input  logic              sram_data_valid_i,
    output logic              sram_ren_o,
    output rv_isa_pkg::xlen_t sram_addr_o,
    output logic              retire_valid_o,
    output rv_isa_pkg::xlen_t retire_pc_o,
    output rv_isa_pkg::inst_t retire_instr_o,
    output rv_isa_pkg::xlen_t reg_a0_o,
    output logic              halted_o
);

    // if/id
    logic                 if_valid;
    rv_isa_pkg::xlen_t    if_pc;
    rv_isa_pkg::inst_t    if_instr;

    // id/ex
    logic                 id_valid;
    rv_isa_pkg::xlen_t    id_pc;
    rv_isa_pkg::inst_t    id_instr;
    rv_isa_pkg::xlen_t    rs1_data;
    rv_isa_pkg::xlen_t    rs2_data;
    rv_isa_pkg::xlen_t    imm;
    rv_isa_pkg::reg_idx_t rs1_idx;
    rv_isa_pkg::reg_idx_t rs2_idx;
    rv_isa_pkg::reg_idx_t rd_idx;
    rv_isa_pkg::alu_op_e  alu_op;
    logic                 use_imm;
    logic                 is_branch;
    logic                 branch_ne;
    logic                 is_jal;
    logic                 id_wb_en;
    logic                 is_ebreak;

    // ex/wb and control
    logic                 jump_taken;
    rv_isa_pkg::xlen_t    jump_target;
    logic                 halt_seen;
    logic                 wb_en;
    rv_isa_pkg::reg_idx_t wb_idx;
    rv_isa_pkg::xlen_t    wb_data;
    logic                 retire_ebreak;
    logic                 fetch_en;
    logic                 flush;

    fetch_stage u_fetch (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .fetch_en_i        (fetch_en),
        .flush_i           (flush),
        .jump_taken_i      (jump_taken),
        .jump_target_i     (jump_target),
        .sram_rdata_i      (sram_rdata_i),
        .sram_data_valid_i (sram_data_valid_i),
        .sram_ren_o        (sram_ren_o),
        .sram_addr_o       (sram_addr_o),
        .if_valid_o        (if_valid),
        .if_pc_o           (if_pc),
        .if_instr_o        (if_instr)
    );

    decode_stage u_decode (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush),
        .if_valid_i  (if_valid),
        .if_pc_i     (if_pc),
        .if_instr_i  (if_instr),
        .wb_en_i     (wb_en),
        .wb_idx_i    (wb_idx),
        .wb_data_i   (wb_data),
        .id_valid_o  (id_valid),
        .id_pc_o     (id_pc),
        .id_instr_o  (id_instr),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data),
        .imm_o       (imm),
        .rs1_idx_o   (rs1_idx),
        .rs2_idx_o   (rs2_idx),
        .rd_idx_o    (rd_idx),
        .alu_op_o    (alu_op),
        .use_imm_o   (use_imm),
        .is_branch_o (is_branch),
        .branch_ne_o (branch_ne),
        .is_jal_o    (is_jal),
        .wb_en_o     (id_wb_en),
        .is_ebreak_o (is_ebreak),
        .reg_a0_o    (reg_a0_o)
    );

    execute_stage u_execute (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .id_valid_i      (id_valid),
        .id_pc_i         (id_pc),
        .id_instr_i      (id_instr),
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (rs2_data),
        .imm_i           (imm),
        .rs1_idx_i       (rs1_idx),
        .rs2_idx_i       (rs2_idx),
        .rd_idx_i        (rd_idx),
        .alu_op_i        (alu_op),
        .use_imm_i       (use_imm),
        .is_branch_i     (is_branch),
        .branch_ne_i     (branch_ne),
        .is_jal_i        (is_jal),
        .wb_en_i         (id_wb_en),
        .is_ebreak_i     (is_ebreak),
        .jump_taken_o    (jump_taken),
        .jump_target_o   (jump_target),
        .halt_seen_o     (halt_seen),
        .wb_en_o         (wb_en),
        .wb_idx_o        (wb_idx),
        .wb_data_o       (wb_data),
        .retire_valid_o  (retire_valid_o),
        .retire_pc_o     (retire_pc_o),
        .retire_instr_o  (retire_instr_o),
        .retire_ebreak_o (retire_ebreak)
    );

    pipeline_ctrl u_ctrl (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .jump_taken_i    (jump_taken),
        .halt_seen_i     (halt_seen),
        .retire_valid_i  (retire_valid_o),
        .retire_ebreak_i (retire_ebreak),
        .fetch_en_o      (fetch_en),
        .flush_o         (flush),
        .halted_o        (halted_o)
    );

endmodule

// File: bench/core_checker.sv
module core_checker (
    input logic              clk,
    input logic              arst_n_i,
    input logic              sram_ren_i,
    input logic              sram_data_valid_i,
    input rv_isa_pkg::xlen_t sram_addr_i,
    input logic              retire_valid_i,
    input rv_isa_pkg::xlen_t retire_pc_i,
    input logic              halted_i
);

    int fail_count = 0;

    // an open read keeps its request and address until data returns
    addr_stable_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        (sram_ren_i && !sram_data_valid_i) |=> (sram_ren_i && $stable(sram_addr_i)))
    else begin
        $error("sram request or address changed before its data arrived");
        fail_count++;
    end

    retire_aligned_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        retire_valid_i |-> (retire_pc_i[1:0] == 2'b00))
    else begin
        $error("retired pc is not word aligned");
        fail_count++;
    end

    // only reset clears halted
    halted_sticky_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        halted_i |=> halted_i)
    else begin
        $error("halted fell without a reset");
        fail_count++;
    end

endmodule

// File: bench/core_tb.sv
`include "core_config.svh"

module core_tb;

    // five tests of well under 200 cycles each, with a wide margin
    localparam int MAX_CYCLES = 4000;

    localparam logic [2:0]  F3_ADD = 3'b000;
    localparam logic [2:0]  F3_SLT = 3'b010;
    localparam logic [2:0]  F3_XOR = 3'b100;
    localparam logic [2:0]  F3_OR  = 3'b110;
    localparam logic [2:0]  F3_AND = 3'b111;
    localparam logic [2:0]  F3_BEQ = 3'b000;
    localparam logic [2:0]  F3_BNE = 3'b001;
    localparam logic [31:0] EBREAK = 32'h0010_0073;

    logic              clk;
    logic              arst_n;
    rv_isa_pkg::xlen_t sram_rdata;
    logic              sram_data_valid;
    logic              sram_ren;
    rv_isa_pkg::xlen_t sram_addr;
    logic              retire_valid;
    rv_isa_pkg::xlen_t retire_pc;
    rv_isa_pkg::inst_t retire_instr;
    rv_isa_pkg::xlen_t reg_a0;
    logic              halted;

    logic [31:0] sram_words [256];
    logic [31:0] prog_q [$];
    logic [31:0] exp_pc_q [$];
    logic [31:0] exp_a0;
    logic [31:0] next_exp_pc;
    string       test_name;
    int          lat_fixed;
    bit          lat_random;
    int          cur_lat;
    int          req_age;
    int          check_count;
    int          error_count;
    int          cycle_count;

    core_top i_dut (
        .clk               (clk),
        .arst_n_i          (arst_n),
        .sram_rdata_i      (sram_rdata),
        .sram_data_valid_i (sram_data_valid),
        .sram_ren_o        (sram_ren),
        .sram_addr_o       (sram_addr),
        .retire_valid_o    (retire_valid),
        .retire_pc_o       (retire_pc),
        .retire_instr_o    (retire_instr),
        .reg_a0_o          (reg_a0),
        .halted_o          (halted)
    );

    bind core_top core_checker i_checker (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .sram_ren_i        (sram_ren_o),
        .sram_data_valid_i (sram_data_valid_i),
        .sram_addr_i       (sram_addr_o),
        .retire_valid_i    (retire_valid_o),
        .retire_pc_i       (retire_pc_o),
        .halted_i          (halted_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // instruction encoders
    function automatic logic [31:0] r_type(input logic sub, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input int imm);
        return {imm[11:0], rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input int off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("CHECK FAILED: %s %s expected %h actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    // SRAM model, one latency draw per request
    initial begin
        void'($urandom(12408));
        forever begin
            @(posedge clk);
            #2;
            if (sram_ren) begin
                if (req_age == 0) begin
                    cur_lat = lat_random ? $urandom_range(4, 1) : lat_fixed;
                end
                req_age = req_age + 1;
                if (req_age >= cur_lat) begin
                    sram_data_valid = 1'b1;
                    sram_rdata      = sram_words[sram_addr[9:2]];
                    req_age         = 0;
                end else begin
                    sram_data_valid = 1'b0;
                end
            end else begin
                sram_data_valid = 1'b0;
                req_age         = 0;
            end
        end
    end

    // retire trace against the reference sequence
    always @(negedge clk) begin
        if (arst_n && retire_valid) begin
            assert (exp_pc_q.size() != 0) else begin
                error_count++;
                $display("%s: instruction at pc %h retired after the expected sequence ended",
                         test_name, retire_pc);
            end
            if (exp_pc_q.size() != 0) begin
                next_exp_pc = exp_pc_q.pop_front();
                check_value("retire pc", next_exp_pc, retire_pc);
                check_value("retire instr", sram_words[next_exp_pc[9:2]], retire_instr);
            end
        end
    end

    task automatic load_program();
        int i;
        // unused words never decode to a supported opcode
        for (i = 0; i < 256; i++) begin
            sram_words[i] = 32'hdead_0000 ^ (i << 2);
        end
        for (i = 0; i < prog_q.size(); i++) begin
            sram_words[i] = prog_q[i];
        end
    endtask

    // instruction-level model of the subset, stops after ebreak
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic [2:0]  f3;
        bit          wr;
        bit          done;
        int          steps;
        int          k;
        for (k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        exp_pc_q.delete();
        pc    = `RESET_PC;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 200) begin
            ins     = sram_words[pc[9:2]];
            f3      = ins[14:12];
            a       = regs[ins[19:15]];
            b       = regs[ins[24:20]];
            imm     = {{20{ins[31]}}, ins[31:20]};
            next_pc = pc + 32'd4;
            wr      = 1'b0;
            res     = '0;
            exp_pc_q.push_back(pc);
            case (ins[6:0])
                7'b0110011: begin
                    wr = 1'b1;
                    case (f3)
                        F3_ADD: res = ins[30] ? a - b : a + b;
                        F3_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        F3_XOR: res = a ^ b;
                        F3_OR:  res = a | b;
                        F3_AND: res = a & b;
                        default: wr = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    wr = 1'b1;
                    case (f3)
                        F3_ADD: res = a + imm;
                        F3_XOR: res = a ^ imm;
                        F3_OR:  res = a | imm;
                        F3_AND: res = a & imm;
                        default: wr = 1'b0;
                    endcase
                end
                7'b0110111: begin
                    wr  = 1'b1;
                    res = {ins[31:12], 12'b0};
                end
                7'b1100011: begin
                    imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    if ((f3 == F3_BEQ && a == b) || (f3 == F3_BNE && a != b)) begin
                        next_pc = pc + imm;
                    end
                end
                7'b1101111: begin
                    wr      = 1'b1;
                    res     = pc + 32'd4;
                    next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                7'b1110011: done = (ins == EBREAK);
                default: ;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                regs[ins[11:7]] = res;
            end
            pc    = next_pc;
            steps = steps + 1;
        end
        exp_a0 = regs[10];
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2 arst_n = 1'b0;
        repeat (7) @(posedge clk);
        @(negedge clk);
        check_value("ren in reset", 32'd0, sram_ren);
        check_value("retire valid in reset", 32'd0, retire_valid);
        check_value("halted in reset", 32'd0, halted);
        @(posedge clk);
        #2 arst_n = 1'b1;
    endtask

    task automatic run_program(input string name, input int lat, input bit rnd);
        test_name  = name;
        lat_fixed  = lat;
        lat_random = rnd;
        load_program();
        run_model();
        apply_reset();
        @(posedge clk);
        @(negedge clk);
        check_value("first request", 32'd1, sram_ren);
        check_value("first address", `RESET_PC, sram_addr);
        while (halted !== 1'b1) begin
            @(negedge clk);
        end
        check_value("a0", exp_a0, reg_a0);
        assert (exp_pc_q.size() == 0) else begin
            error_count++;
            $display("%s: core halted with %0d expected instructions not retired",
                     test_name, exp_pc_q.size());
        end
    endtask

    task automatic alu_immediate_test();
        prog_q.delete();
        prog_q.push_back(u_type(5'd10, 20'h12345));
        prog_q.push_back(i_type(F3_ADD, 5'd10, 5'd10, 'h678));
        prog_q.push_back(i_type(F3_XOR, 5'd10, 5'd10, -1));
        prog_q.push_back(i_type(F3_AND, 5'd1, 5'd10, 'h7f0));
        prog_q.push_back(i_type(F3_OR, 5'd10, 5'd1, 'h00f));
        prog_q.push_back(i_type(F3_ADD, 5'd10, 5'd10, -256));
        prog_q.push_back(i_type(F3_XOR, 5'd10, 5'd10, 'h555));
        prog_q.push_back(EBREAK);
        run_program("alu_immediate", 1, 1'b0);
    endtask

    // distance one uses the bypass, distance two the write-through
    task automatic build_forwarding_program();
        prog_q.delete();
        prog_q.push_back(i_type(F3_ADD, 5'd1, 5'd0, 7));
        prog_q.push_back(i_type(F3_ADD, 5'd2, 5'd0, -3));
        prog_q.push_back(r_type(1'b0, F3_ADD, 5'd3, 5'd1, 5'd2));
        prog_q.push_back(r_type(1'b1, F3_ADD, 5'd10, 5'd3, 5'd1));
        prog_q.push_back(r_type(1'b0, F3_SLT, 5'd4, 5'd10, 5'd3));
        prog_q.push_back(r_type(1'b0, F3_ADD, 5'd10, 5'd10, 5'd4));
        prog_q.push_back(r_type(1'b1, F3_ADD, 5'd10, 5'd10, 5'd2));
        prog_q.push_back(r_type(1'b0, F3_AND, 5'd5, 5'd10, 5'd1));
        prog_q.push_back(r_type(1'b0, F3_OR, 5'd10, 5'd10, 5'd3));
        prog_q.push_back(r_type(1'b0, F3_XOR, 5'd10, 5'd10, 5'd5));
        prog_q.push_back(r_type(1'b0, F3_SLT, 5'd10, 5'd2, 5'd10));
        prog_q.push_back(r_type(1'b0, F3_ADD, 5'd10, 5'd10, 5'd3));
        prog_q.push_back(EBREAK);
    endtask

    task automatic forwarding_test();
        build_forwarding_program();
        run_program("forwarding", 1, 1'b0);
    endtask

    task automatic branches_test();
        prog_q.delete();
        prog_q.push_back(i_type(F3_ADD, 5'd1, 5'd0, 5));
        prog_q.push_back(i_type(F3_ADD, 5'd2, 5'd0, 5));
        prog_q.push_back(i_type(F3_ADD, 5'd10, 5'd0, 1));
        prog_q.push_back(b_type(F3_BEQ, 5'd1, 5'd2, 12));
        prog_q.push_back(i_type(F3_ADD, 5'd10, 5'd0, 99));
        prog_q.push_back(i_type(F3_ADD, 5'd10, 5'd0, 98));
        prog_q.push_back(b_type(F3_BNE, 5'd1, 5'd2, 8));
        prog_q.push_back(i_type(F3_ADD, 5'd3, 5'd0, 6));
        prog_q.push_back(b_type(F3_BEQ, 5'd1, 5'd3, 8));
        prog_q.push_back(b_type(F3_BNE, 5'd1, 5'd3, 12));
        prog_q.push_back(i_type(F3_ADD, 5'd10, 5'd0, 97));
        prog_q.push_back(i_type(F3_ADD, 5'd10, 5'd0, 96));
        prog_q.push_back(j_type(5'd10, 12));
        prog_q.push_back(i_type(F3_ADD, 5'd10, 5'd0, 95));
        prog_q.push_back(i_type(F3_ADD, 5'd10, 5'd0, 94));
        prog_q.push_back(EBREAK);
        run_program("branches", 1, 1'b0);
    endtask

    task automatic random_latency_test();
        build_forwarding_program();
        run_program("random_latency", 1, 1'b1);
    endtask

    task automatic halt_test();
        prog_q.delete();
        prog_q.push_back(i_type(F3_ADD, 5'd10, 5'd0, 42));
        prog_q.push_back(i_type(F3_ADD, 5'd1, 5'd10, 1));
        prog_q.push_back(EBREAK);
        prog_q.push_back(i_type(F3_ADD, 5'd10, 5'd0, 1));
        prog_q.push_back(i_type(F3_ADD, 5'd10, 5'd0, 2));
        prog_q.push_back(j_type(5'd0, -20));
        run_program("halt", 1, 1'b0);
        repeat (12) begin
            @(negedge clk);
            check_value("ren after halt", 32'd0, sram_ren);
            check_value("halted level", 32'd1, halted);
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the core never halted within %0d cycles", MAX_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        arst_n          = 1'b0;
        sram_rdata      = '0;
        sram_data_valid = 1'b0;
        lat_fixed       = 1;
        lat_random      = 1'b0;
        cur_lat         = 1;
        req_age         = 0;
        check_count     = 0;
        error_count     = 0;
        test_name       = "init";
        alu_immediate_test();
        forwarding_test();
        branches_test();
        random_latency_test();
        halt_test();
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, i_dut.i_checker.fail_count);
        if (error_count == 0 && i_dut.i_checker.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/pipeline_ctrl.sv
verilog/core_top.sv
bench/core_checker.sv
bench/core_tb.sv
